// File: decache.f
+incdir+common
common/decache_pkg.sv
logic/line_refill.sv
decache/cache_store.sv
decache/decache_ctrl.sv
decache/decache.sv
bench/axi_mem_model.sv
bench/decache_assertions.sv
bench/decache_tb.sv

// File: Bender.yml
package:
  name: decache

export_include_dirs:
  - common

sources:
  - files:
      - common/decache_pkg.sv
      - logic/line_refill.sv
      - decache/cache_store.sv
      - decache/decache_ctrl.sv
      - decache/decache.sv
  - target: test
    files:
      - bench/axi_mem_model.sv
      - bench/decache_assertions.sv
      - bench/decache_tb.sv

// File: bench/decache_tb.sv
`include "decache_defines.svh"

module decache_tb;
    import decache_pkg::*;

    localparam int    seed_value  = 16794;
    localparam int    load_count  = 400;
    localparam int    pool_lines  = 15;  // Five lines per set over three sets
    localparam word_t data_pattern = 32'h5a3c_96e1;
    localparam int    miss_cycles = 40;  // Worst-case miss incl. arready wait and beat gaps
    localparam int    watchdog_cycles = 16 + load_count * (miss_cycles + 8);

    logic  clock;
    logic  reset;
    logic  req;
    addr_t address;
    logic  ack;
    word_t read_data;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    beat_t rdata;
    logic  rlast;
    logic  rready;

    int    seed = seed_value;
    int    burst_count = 0;  // AR handshakes seen
    addr_t burst_addr;
    addr_t pool [pool_lines];

    // Mirror of the tag state
    tag_t  model_tag   [`DECACHE_SETS][`DECACHE_WAYS];
    logic  model_valid [`DECACHE_SETS][`DECACHE_WAYS];
    int    model_rr    [`DECACHE_SETS];

    decache decache_i (.*);

    axi_mem_model #(.seed_start(seed_value), .data_pattern(data_pattern)) mem_i (
        .clock(clock), .reset(reset), .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rlast(rlast), .rready(rready)
    );

    bind decache decache_assertions assertions_i (
        .clock(clock), .reset(reset), .req(req), .ack(ack),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        if (!reset && arvalid && arready) begin
            burst_count <= burst_count + 1;
            burst_addr  <= araddr;
        end
    end

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected) else begin
            $display("mismatch at time %0t: %s got %0h expected %0h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    function automatic word_t expected_word(input addr_t a);
        return word_t'(a >> 2) ^ data_pattern;
    endfunction

    // Returns 1 on a hit and on a miss fills the mirror like the cache does
    function automatic logic model_access(input addr_t a);
        tag_t t;
        int   s;
        int   victim;
        t = a[`DECACHE_ADDR_WIDTH-1 -: `DECACHE_TAG_BITS];
        s = a[`DECACHE_OFFSET_BITS +: `DECACHE_INDEX_BITS];
        for (int w = 0; w < `DECACHE_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) return 1'b1;
        end
        victim = model_rr[s];
        for (int w = `DECACHE_WAYS - 1; w >= 0; w--) begin
            if (!model_valid[s][w]) victim = w;  // Lowest free way first
        end
        model_valid[s][victim] = 1'b1;
        model_tag[s][victim]   = t;
        model_rr[s] = (model_rr[s] + 1) % `DECACHE_WAYS;  // Moves on every refill
        return 1'b0;
    endfunction

    task automatic do_load(input addr_t a);
        logic hit_expected;
        int   bursts_before;
        int   cycles;
        hit_expected  = model_access(a);
        bursts_before = burst_count;
        @(posedge clock);
        req     <= 1'b1;
        address <= a;
        @(posedge clock);  // DUT samples req here
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end while (!ack);
        compare_value("read_data", read_data, expected_word(a));
        if (hit_expected) begin
            compare_value("ack latency", cycles, 2);
            compare_value("burst count on hit", burst_count - bursts_before, 0);
        end else begin
            compare_value("burst count on miss", burst_count - bursts_before, 1);
            compare_value("araddr", burst_addr, a & ~addr_t'(`DECACHE_LINE_BYTES - 1));
        end
        @(posedge clock);
        req <= 1'b0;
        @(negedge clock);
        compare_value("ack before release", ack, 1'b1);  // Req drop not yet seen by the DUT
        @(posedge clock);
        @(negedge clock);
        compare_value("ack after release", ack, 1'b0);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, a load never finished", watchdog_cycles);
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        addr_t a;
        int    pick;
        int    gap;
        reset   = 1'b1;
        req     = 1'b0;
        address = '0;
        for (int i = 0; i < pool_lines; i++) begin
            pool[i] = {tag_t'(56'h00_00a5_c300_0000 + i), set_index_t'(i % 3),
                       {`DECACHE_OFFSET_BITS{1'b0}}};
        end
        for (int s = 0; s < `DECACHE_SETS; s++) begin
            model_rr[s] = 0;
            for (int w = 0; w < `DECACHE_WAYS; w++) model_valid[s][w] = 1'b0;
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_value("ack", ack, 1'b0);
        compare_value("arvalid", arvalid, 1'b0);
        compare_value("rready", rready, 1'b0);
        for (int n = 0; n < load_count; n++) begin
            pick = $unsigned($random(seed)) % pool_lines;
            a    = pool[pick] | addr_t'(($random(seed) & 15) << 2);  // Random word of the line
            gap  = $random(seed) & 3;
            repeat (gap) @(posedge clock);
            do_load(a);
        end
        repeat (2) @(posedge clock);
        if (decache_i.assertions_i.failure_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "Bound assertions failed");
        end
    end

endmodule

// File: bench/decache_assertions.sv
module decache_assertions (
    input logic                clock,
    input logic                reset,
    input logic                req,
    input logic                ack,
    input logic                arvalid,
    input decache_pkg::addr_t  araddr,
    input logic                arready,
    input logic                rvalid,
    input logic                rready
);
    int failure_count = 0;  // Failed assertions so far

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge clock) disable iff (reset) $rose(ack) |-> req)
        else begin
            $error("ack rose while req was low");
            failure_count++;
        end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before arready");
            failure_count++;
        end

    // Memory paces the burst only through rvalid gaps
    r_open: assert property (@(posedge clock) disable iff (reset)
        rvalid |-> rready)
        else begin
            $error("rvalid offered a beat while rready was low");
            failure_count++;
        end

endmodule

// File: bench/axi_mem_model.sv
`include "decache_defines.svh"

module axi_mem_model #(
    parameter int                 seed_start   = 1,
    parameter decache_pkg::word_t data_pattern = '0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                arvalid,
    input  decache_pkg::addr_t  araddr,
    output logic                arready,
    output logic                rvalid,
    output decache_pkg::beat_t  rdata,
    output logic                rlast,
    input  logic                rready
);
    import decache_pkg::*;

    int    seed = seed_start;
    logic  busy;   // Burst in progress
    int    beat;   // Beats already taken
    int    delay;  // Cycles left before ready or next beat
    addr_t base;

    // Word contents follow the address
    function automatic word_t word_at(input addr_t a);
        return word_t'(a >> 2) ^ data_pattern;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            busy  = 1'b0;
            beat  = 0;
            delay = 2;
        end else if (!busy) begin
            if (arvalid && arready) begin  // Address taken, burst starts
                arready <= 1'b0;
                base  = araddr;
                busy  = 1'b1;
                beat  = 0;
                delay = $random(seed) & 1;
            end else if (arvalid) begin
                if (delay == 0) arready <= 1'b1;
                else delay--;
            end
        end else if (!rvalid || rready) begin
            if (rvalid) begin  // Beat went through on this edge
                beat++;
                delay = $random(seed) & 1;
            end
            if (beat == `DECACHE_BEATS) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                busy  = 1'b0;
                delay = $random(seed) & 3;  // Next arready wait
            end else if (delay == 0) begin
                rvalid <= 1'b1;
                rlast  <= (beat == `DECACHE_BEATS - 1);
                // Low word sits at the low address
                rdata  <= {word_at(base + addr_t'(8 * beat + 4)), word_at(base + addr_t'(8 * beat))};
            end else begin
                rvalid <= 1'b0;  // Gap in the burst
                rlast  <= 1'b0;
                delay--;
            end
        end
    end

endmodule

// File: decache/decache.sv
module decache (
    input  logic                 clock,
    input  logic                 reset,
    // Load port, four-phase req/ack
    input  logic                 req,
    input  decache_pkg::addr_t   address,
    output logic                 ack,
    output decache_pkg::word_t   read_data,
    // AXI read address channel
    output logic                 arvalid,
    output decache_pkg::addr_t   araddr,
    input  logic                 arready,
    // AXI read data channel
    input  logic                 rvalid,
    input  decache_pkg::beat_t   rdata,
    input  logic                 rlast,
    output logic                 rready
);
    import decache_pkg::*;

    logic       hit;           // Tag match in indexed set
    line_t      hit_line;
    logic       refill_start;  // One-cycle pulse to refill engine
    addr_t      refill_addr;
    logic       refill_done;
    line_t      refill_line;   // Fetched line, also the fill data
    set_index_t lookup_index;
    tag_t       lookup_tag;
    logic       fill_en;

    // Handshake FSM and hit/miss decision
    decache_ctrl ctrl_i (
        .clock        (clock),
        .reset        (reset),
        .req          (req),
        .address      (address),
        .ack          (ack),
        .read_data    (read_data),
        .hit          (hit),
        .hit_line     (hit_line),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .fill_en      (fill_en)
    );

    line_refill refill_i (
        .clock        (clock),
        .reset        (reset),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rlast        (rlast),
        .rready       (rready)
    );

    // Tag/data arrays, fill takes the refill buffer directly
    cache_store store_i (
        .clock        (clock),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_line     (hit_line),
        .fill_en      (fill_en),
        .fill_line    (refill_line)
    );

endmodule

// File: decache/decache_ctrl.sv
`include "decache_defines.svh"

module decache_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req,
    input  decache_pkg::addr_t       address,
    output logic                     ack,
    output decache_pkg::word_t       read_data,
    input  logic                     hit,
    input  decache_pkg::line_t       hit_line,
    output logic                     refill_start,
    output decache_pkg::addr_t       refill_addr,
    input  logic                     refill_done,
    input  decache_pkg::line_t       refill_line,
    output decache_pkg::set_index_t  lookup_index,
    output decache_pkg::tag_t        lookup_tag,
    output logic                     fill_en
);
    import decache_pkg::*;

    ctrl_state_t state;
    addr_t       req_addr;   // Address captured at req
    logic        miss_seen;  // Word comes from the refill buffer
    word_sel_t   word_sel;
    line_t       src_line;

    // Address split, held stable until the next request
    assign lookup_tag   = req_addr[`DECACHE_ADDR_WIDTH-1 -: `DECACHE_TAG_BITS];
    assign lookup_index = req_addr[`DECACHE_OFFSET_BITS +: `DECACHE_INDEX_BITS];
    assign word_sel     = req_addr[`DECACHE_OFFSET_BITS-1:2];  // Drop byte-in-word bits
    assign refill_addr  = {lookup_tag, lookup_index, {`DECACHE_OFFSET_BITS{1'b0}}};

    // Store writes the line on the same edge the FSM leaves refill
    assign fill_en  = (state == state_refill) && refill_done;
    assign src_line = miss_seen ? refill_line : hit_line;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= state_idle;
            ack          <= 1'b0;
            refill_start <= 1'b0;
            miss_seen    <= 1'b0;
        end else begin
            refill_start <= 1'b0;  // Pulse only
            case (state)
                state_idle: begin
                    if (req) begin
                        state     <= state_lookup;
                        miss_seen <= 1'b0;
                    end
                end
                state_lookup: begin
                    if (hit) begin
                        state <= state_respond;
                    end else begin
                        state        <= state_refill;
                        refill_start <= 1'b1;
                        miss_seen    <= 1'b1;
                    end
                end
                state_refill: begin
                    if (refill_done) state <= state_respond;
                end
                state_respond: begin
                    ack   <= 1'b1;  // read_data registered alongside
                    state <= state_release;
                end
                state_release: begin
                    // Four-phase, ack follows req down
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Payload, address capture and word select
    always_ff @(posedge clock) begin
        if (state == state_idle && req) req_addr <= address;
        if (state == state_respond) begin
            read_data <= src_line[word_sel*`DECACHE_WORD_WIDTH +: `DECACHE_WORD_WIDTH];
        end
    end

endmodule

// File: decache/cache_store.sv
`include "decache_defines.svh"

module cache_store (
    input  logic                     clock,
    input  logic                     reset,
    input  decache_pkg::set_index_t  lookup_index,
    input  decache_pkg::tag_t        lookup_tag,
    output logic                     hit,
    output decache_pkg::line_t       hit_line,
    input  logic                     fill_en,
    input  decache_pkg::line_t       fill_line
);
    import decache_pkg::*;

    tag_t                    tag_mem   [`DECACHE_SETS][`DECACHE_WAYS];
    line_t                   data_mem  [`DECACHE_SETS][`DECACHE_WAYS];
    logic [`DECACHE_WAYS-1:0] valid_mem [`DECACHE_SETS];  // One bit per way
    way_t                    rr_ptr    [`DECACHE_SETS];   // Round-robin victim pointer

    logic [`DECACHE_WAYS-1:0] match;
    way_t                    victim;

    // Parallel compare across the indexed set
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DECACHE_WAYS; w++) begin
            match[w] = valid_mem[lookup_index][w] &&
                       (tag_mem[lookup_index][w] == lookup_tag);
            if (match[w]) hit_line = data_mem[lookup_index][w];  // At most one match
        end
    end

    assign hit = |match;

    // Victim choice
    always_comb begin
        victim = rr_ptr[lookup_index];  // Full set falls back to pointer
        // Walk downward so the lowest invalid way wins
        for (int w = `DECACHE_WAYS-1; w >= 0; w--) begin
            if (!valid_mem[lookup_index][w]) victim = way_t'(w);
        end
    end

    // Valid bits and pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DECACHE_SETS; s++) begin
                valid_mem[s] <= '0;
                rr_ptr[s]    <= '0;
            end
        end else if (fill_en) begin
            valid_mem[lookup_index][victim] <= 1'b1;
            // Pointer moves on every refill of this set
            rr_ptr[lookup_index] <= way_t'(rr_ptr[lookup_index] + 1'b1);
        end
    end

    // Tag and line arrays
    always_ff @(posedge clock) begin
        if (fill_en) begin
            tag_mem[lookup_index][victim]  <= lookup_tag;
            data_mem[lookup_index][victim] <= fill_line;
        end
    end

endmodule

// File: logic/line_refill.sv
`include "decache_defines.svh"

module line_refill (
    input  logic                clock,
    input  logic                reset,
    // Controller side
    input  logic                refill_start,
    input  decache_pkg::addr_t  refill_addr,
    output logic                refill_done,
    output decache_pkg::line_t  refill_line,
    // AXI read channels
    output logic                arvalid,
    output decache_pkg::addr_t  araddr,
    input  logic                arready,
    input  logic                rvalid,
    input  decache_pkg::beat_t  rdata,
    input  logic                rlast,
    output logic                rready
);
    import decache_pkg::*;

    beat_sel_t beat_cnt;  // Next beat slot in the line buffer
    logic      ar_fire;
    logic      r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Burst control
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            refill_done <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            refill_done <= 1'b0;
            if (refill_start) begin
                arvalid  <= 1'b1;  // Held until arready
                beat_cnt <= '0;
            end
            if (ar_fire) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;   // Open for whole burst
            end
            if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (rlast) begin
                    rready      <= 1'b0;
                    refill_done <= 1'b1;
                end
            end
        end
    end

    // Address and line buffer, payload only
    always_ff @(posedge clock) begin
        if (refill_start) araddr <= refill_addr;  // Already line aligned
        if (r_fire) begin
            // Beats arrive in address order, low word at low address
            refill_line[beat_cnt*`DECACHE_BEAT_WIDTH +: `DECACHE_BEAT_WIDTH] <= rdata;
        end
    end

endmodule

// File: common/decache_pkg.sv
`include "decache_defines.svh"

package decache_pkg;

    typedef logic [`DECACHE_ADDR_WIDTH-1:0]                addr_t;      // Byte address
    typedef logic [`DECACHE_TAG_BITS-1:0]                  tag_t;       // Upper address field
    typedef logic [`DECACHE_INDEX_BITS-1:0]                set_index_t; // Set select
    typedef logic [$clog2(`DECACHE_WAYS)-1:0]              way_t;
    typedef logic [$clog2(`DECACHE_LINE_BYTES/4)-1:0]      word_sel_t;  // Word within line
    typedef logic [$clog2(`DECACHE_BEATS)-1:0]             beat_sel_t;  // Beat within burst
    typedef logic [`DECACHE_WORD_WIDTH-1:0]                word_t;
    typedef logic [`DECACHE_BEAT_WIDTH-1:0]                beat_t;
    typedef logic [`DECACHE_LINE_BYTES*8-1:0]              line_t;      // Whole cache line

    // Load controller states
    typedef enum logic [2:0] {
        state_idle,     // Waiting for req
        state_lookup,   // One cycle of tag compare
        state_refill,   // Line fetch in progress
        state_respond,  // Register word, raise ack
        state_release   // Hold ack until req drops
    } ctrl_state_t;

endpackage

// File: common/decache_defines.svh
`ifndef DECACHE_DEFINES_SVH
`define DECACHE_DEFINES_SVH

// Bus widths
`define DECACHE_ADDR_WIDTH  64  // Byte address
`define DECACHE_WORD_WIDTH  32  // Load word
`define DECACHE_BEAT_WIDTH  64  // One AXI read beat

// Line geometry
`define DECACHE_LINE_BYTES  64
`define DECACHE_BEATS       8   // Beats per line refill

// Cache organization
`define DECACHE_SETS        4
`define DECACHE_WAYS        4

// Address split, tag | index | offset
`define DECACHE_OFFSET_BITS 6
`define DECACHE_INDEX_BITS  2
`define DECACHE_TAG_BITS    56

`endif
